//--- hdl/hitMapPkg.sv
package hitMapPkg;

    // map geometry
    localparam int ROWBITS = 5;                       // row index width, 32 rows
    localparam int COLBITS = 4;                       // column index width
    localparam int NUMROWS = 1 << ROWBITS;            // rows in the RAM
    localparam int NUMCOLS = 1 << COLBITS;            // bits per row, 16
    localparam int SSIDBITS = ROWBITS + COLBITS;      // full superstrip id width

    // timing
    localparam int READLATENCY = 2;                   // RAM address to data, in cycles
    localparam int CLEARSETTLE = 4;                   // idle cycles after the last cleared row
    localparam int SETTLEBITS = $clog2(CLEARSETTLE + 1); // settle counter width

    // command kinds on the host port
    typedef logic [1:0] opCode;
    localparam opCode OPSETHIT = 2'd0;                // OR one bit into the map
    localparam opCode OPREADBIT = 2'd1;               // return one bit
    localparam opCode OPREADROW = 2'd2;               // return a whole row

    // clear FSM states
    localparam logic [1:0] CLRCLEARING = 2'd0;        // writing zero, one row per cycle
    localparam logic [1:0] CLRSETTLING = 2'd1;        // waiting out the settle delay
    localparam logic [1:0] CLRIDLE = 2'd2;            // normal operation

    // one RAM row
    typedef logic [NUMCOLS-1:0] rowWord;

    // an SSID seen flat, or split into row (upper bits) and column (lower bits)
    typedef union packed {
        logic [SSIDBITS-1:0] flat;                    // as sent by the host
        struct packed {
            logic [ROWBITS-1:0] row;                  // selects the RAM row
            logic [COLBITS-1:0] col;                  // selects the bit in that row
        } rc;
    } ssidWord;

endpackage

//--- hdl/hitMapRam.sv
`timescale 1ns/10ps

module hitMapRam (
    input  logic                            clk,
    input  logic                            wrEn,    // write strobe
    input  logic [hitMapPkg::ROWBITS-1:0]   wrRow,   // write address
    input  hitMapPkg::rowWord               wrData,  // row written whole
    input  logic [hitMapPkg::ROWBITS-1:0]   rdRow,   // read address, sampled every cycle
    output hitMapPkg::rowWord               rdData   // data READLATENCY cycles after rdRow
);

    hitMapPkg::rowWord mem [hitMapPkg::NUMROWS];        // storage array, cleared by the clear pass
    hitMapPkg::rowWord rdPipe [hitMapPkg::READLATENCY]; // registered read stages

    logic bypass; // read and write hit the same row this cycle

    assign bypass = wrEn && (wrRow == rdRow); // write-first collision

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrRow] <= wrData; // single row write
        end
    end

    always_ff @(posedge clk) begin
        // first stage samples the array, or the incoming data on a collision
        rdPipe[0] <= bypass ? wrData : mem[rdRow];
        for (int k = 1; k < hitMapPkg::READLATENCY; k++) begin
            rdPipe[k] <= rdPipe[k - 1]; // output register chain
        end
    end

    // later stages need no bypass, the command port spaces same-row
    // accesses at least READLATENCY cycles apart
    assign rdData = rdPipe[hitMapPkg::READLATENCY - 1]; // last stage drives the port

endmodule

//--- hdl/commandPort.sv
`timescale 1ns/10ps

module commandPort (
    input  logic                            clk,
    input  logic                            reset,
    // host side, four-phase req/ack
    input  logic                            cmdReq,     // host request, fields stable while high
    input  hitMapPkg::opCode                cmdOp,      // command kind
    input  hitMapPkg::ssidWord              cmdSsid,    // target of set and bit read
    input  logic [hitMapPkg::ROWBITS-1:0]   cmdRow,     // target of row read only
    output logic                            cmdAck,     // acknowledge, rises on acceptance
    // back-pressure
    input  logic                            busy,       // clear pass running
    input  logic                            setPending, // sets still in flight
    // RAM read address
    output logic [hitMapPkg::ROWBITS-1:0]   rdRow,      // valid in the acceptance cycle
    // set path
    output logic                            setValid,   // accepted set, one cycle
    output logic [hitMapPkg::ROWBITS-1:0]   setRow,
    output logic [hitMapPkg::COLBITS-1:0]   setCol,
    // read path
    output logic                            readValid,  // accepted read, one cycle
    output logic                            readIsRow,  // whole-row read
    output logic [hitMapPkg::ROWBITS-1:0]   readRow,
    output logic [hitMapPkg::COLBITS-1:0]   readCol
);

    logic isSet;    // op decodes to a hit set
    logic isRead;   // op decodes to either read
    logic isRowOp;  // op is the whole-row read
    logic blocked;  // back-pressure holds the command
    logic accept;   // command taken this cycle

    // op decode
    assign isSet = (cmdOp == hitMapPkg::OPSETHIT);
    assign isRowOp = (cmdOp == hitMapPkg::OPREADROW);
    assign isRead = isRowOp || (cmdOp == hitMapPkg::OPREADBIT);

    // busy stalls everything, pending sets stall reads so no stale row is returned
    assign blocked = busy || (isRead && setPending);

    // only a fresh request with ack low, so one command per handshake
    assign accept = cmdReq && !cmdAck && !blocked;

    always_ff @(posedge clk) begin
        if (reset) begin
            cmdAck <= 1'b0;                 // idle handshake
        end else if (accept) begin
            cmdAck <= 1'b1;                 // phase 2, ack rises
        end else if (cmdAck && !cmdReq) begin
            cmdAck <= 1'b0;                 // phase 4, host has dropped req
        end
    end

    // read address goes out for every command, a set needs the old row too
    assign rdRow = isRowOp ? cmdRow : cmdSsid.rc.row;

    // set dispatch
    assign setValid = accept && isSet;
    assign setRow = cmdSsid.rc.row;         // row half of the ssid
    assign setCol = cmdSsid.rc.col;         // column half

    // read dispatch, unused op codes are acked and dropped
    assign readValid = accept && isRead;
    assign readIsRow = isRowOp;
    assign readRow = rdRow;                 // same row the RAM is fetching
    assign readCol = cmdSsid.rc.col;        // ignored for row reads

endmodule

//--- hdl/hitMergePipe.sv
`timescale 1ns/10ps

module hitMergePipe (
    input  logic                            clk,
    input  logic                            reset,
    // accepted sets from the command port
    input  logic                            setValid,
    input  logic [hitMapPkg::ROWBITS-1:0]   setRow,
    input  logic [hitMapPkg::COLBITS-1:0]   setCol,
    // old row contents from the RAM
    input  hitMapPkg::rowWord               rdData,
    // status and write-back
    output logic                            setPending,  // any entry live
    output logic                            mergeWrEn,   // exit entry writes back
    output logic [hitMapPkg::ROWBITS-1:0]   mergeWrRow,
    output hitMapPkg::rowWord               mergeWrData  // old row OR new hits
);

    // delay line, entry k has been in flight k+1 cycles
    logic [hitMapPkg::READLATENCY-1:0] entryValid;
    logic [hitMapPkg::ROWBITS-1:0]     entryRow [hitMapPkg::READLATENCY];
    hitMapPkg::rowWord                 entryMask [hitMapPkg::READLATENCY]; // hits to OR in

    hitMapPkg::rowWord                 setMask;  // one-hot column of the incoming set
    logic [hitMapPkg::READLATENCY-1:0] mergeHit; // incoming set joins entry k
    logic                              merged;   // incoming set joined some entry

    always_comb begin
        setMask = '0;
        setMask[setCol] = 1'b1;             // decode column to a bit
        mergeHit = '0;
        // the exit entry is already writing back, so it takes no more hits
        for (int k = 0; k < hitMapPkg::READLATENCY - 1; k++) begin
            mergeHit[k] = setValid && entryValid[k] && (entryRow[k] == setRow);
        end
    end

    assign merged = |mergeHit;

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;               // drop anything in flight
        end else begin
            entryValid[0] <= setValid && !merged; // new entry only if nothing to join
            for (int k = 1; k < hitMapPkg::READLATENCY; k++) begin
                entryValid[k] <= entryValid[k - 1];
            end
        end
    end

    // payload, shifts every cycle
    always_ff @(posedge clk) begin
        entryRow[0] <= setRow;
        entryMask[0] <= setMask;
        for (int k = 1; k < hitMapPkg::READLATENCY; k++) begin
            entryRow[k] <= entryRow[k - 1];
            // a merged hit rides on the older entry as it moves up
            entryMask[k] <= mergeHit[k - 1] ? (entryMask[k - 1] | setMask)
                                            : entryMask[k - 1];
        end
    end

    assign setPending = |entryValid;

    // exit entry lines up with the RAM data fetched at its acceptance
    assign mergeWrEn = entryValid[hitMapPkg::READLATENCY - 1];
    assign mergeWrRow = entryRow[hitMapPkg::READLATENCY - 1];
    assign mergeWrData = rdData | entryMask[hitMapPkg::READLATENCY - 1]; // read-modify-write

endmodule

//--- hdl/readTracker.sv
`timescale 1ns/10ps

module readTracker (
    input  logic                            clk,
    input  logic                            reset,
    // accepted reads from the command port
    input  logic                            readValid,
    input  logic                            readIsRow,
    input  logic [hitMapPkg::ROWBITS-1:0]   readRow,
    input  logic [hitMapPkg::COLBITS-1:0]   readCol,
    // row contents from the RAM
    input  hitMapPkg::rowWord               rdData,
    // results to the host
    output logic                            resultValid,    // one-cycle pulse
    output logic                            resultIsRow,    // which result fields are new
    output logic [hitMapPkg::SSIDBITS-1:0]  resultSsid,     // ssid of a bit read
    output logic                            resultBit,      // stored bit for that ssid
    output logic [hitMapPkg::ROWBITS-1:0]   resultRowIndex, // row of a row read
    output hitMapPkg::rowWord               resultRow       // whole row contents
);

    // tag line matching the RAM read stages
    logic [hitMapPkg::READLATENCY-1:0] tagValid;
    logic [hitMapPkg::READLATENCY-1:0] tagIsRow;
    logic [hitMapPkg::ROWBITS-1:0]     tagRow [hitMapPkg::READLATENCY];
    logic [hitMapPkg::COLBITS-1:0]     tagCol [hitMapPkg::READLATENCY];

    hitMapPkg::ssidWord exitSsid; // exit tag rebuilt into an ssid

    assign exitSsid.rc.row = tagRow[hitMapPkg::READLATENCY - 1];
    assign exitSsid.rc.col = tagCol[hitMapPkg::READLATENCY - 1];

    always_ff @(posedge clk) begin
        if (reset) begin
            tagValid <= '0;
            resultValid <= 1'b0;
        end else begin
            tagValid[0] <= readValid;
            for (int k = 1; k < hitMapPkg::READLATENCY; k++) begin
                tagValid[k] <= tagValid[k - 1];
            end
            resultValid <= tagValid[hitMapPkg::READLATENCY - 1]; // pulse when the tag exits
        end
    end

    always_ff @(posedge clk) begin
        tagIsRow[0] <= readIsRow;
        tagRow[0] <= readRow;
        tagCol[0] <= readCol;
        for (int k = 1; k < hitMapPkg::READLATENCY; k++) begin
            tagIsRow[k] <= tagIsRow[k - 1];
            tagRow[k] <= tagRow[k - 1];
            tagCol[k] <= tagCol[k - 1];
        end
        if (tagValid[hitMapPkg::READLATENCY - 1]) begin
            resultIsRow <= tagIsRow[hitMapPkg::READLATENCY - 1];
            if (tagIsRow[hitMapPkg::READLATENCY - 1]) begin
                resultRowIndex <= exitSsid.rc.row;  // row read, keep the whole word
                resultRow <= rdData;
            end else begin
                resultSsid <= exitSsid.flat;        // bit read, pick one column
                resultBit <= rdData[exitSsid.rc.col];
            end
        end
    end

endmodule

//--- hdl/clearSequencer.sv
`timescale 1ns/10ps

module clearSequencer (
    input  logic                            clk,
    input  logic                            reset,
    // write-back from the merge pipe
    input  logic                            mergeWrEn,
    input  logic [hitMapPkg::ROWBITS-1:0]   mergeWrRow,
    input  hitMapPkg::rowWord               mergeWrData,
    // status
    output logic                            busy,    // high until clear and settle are done
    // RAM write port
    output logic                            wrEn,
    output logic [hitMapPkg::ROWBITS-1:0]   wrRow,
    output hitMapPkg::rowWord               wrData
);

    logic [1:0]                         state;       // clear FSM
    logic [hitMapPkg::ROWBITS-1:0]      clearRow;    // next row to zero
    logic [hitMapPkg::SETTLEBITS-1:0]   settleCount; // cycles spent settling
    logic                               clearing;    // FSM owns the write port

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hitMapPkg::CLRCLEARING;    // every reset starts a fresh clear
            clearRow <= '0;
            settleCount <= '0;
        end else begin
            case (state)
                hitMapPkg::CLRCLEARING: begin
                    clearRow <= clearRow + 1'b1; // one row per cycle
                    if (clearRow == hitMapPkg::ROWBITS'(hitMapPkg::NUMROWS - 1)) begin
                        state <= hitMapPkg::CLRSETTLING; // last row written
                        settleCount <= '0;
                    end
                end
                hitMapPkg::CLRSETTLING: begin
                    settleCount <= settleCount + 1'b1;
                    if (settleCount == hitMapPkg::SETTLEBITS'(hitMapPkg::CLEARSETTLE - 1)) begin
                        state <= hitMapPkg::CLRIDLE;
                    end
                end
                hitMapPkg::CLRIDLE: begin
                    state <= hitMapPkg::CLRIDLE; // stay until the next reset
                end
                default: begin
                    state <= hitMapPkg::CLRCLEARING; // unknown code, clear again
                    clearRow <= '0;
                end
            endcase
        end
    end

    assign clearing = (state == hitMapPkg::CLRCLEARING);
    assign busy = (state != hitMapPkg::CLRIDLE);

    // write port mux, clear pass first, merge write-back only when idle
    assign wrEn = clearing || (!busy && mergeWrEn);
    assign wrRow = clearing ? clearRow : mergeWrRow;
    assign wrData = clearing ? '0 : mergeWrData;

endmodule

//--- hdl/hitMapTop.sv
`timescale 1ns/10ps

module hitMapTop (
    input  logic                            clk,
    input  logic                            reset,
    // host command port
    input  logic                            cmdReq,
    input  hitMapPkg::opCode                cmdOp,
    input  hitMapPkg::ssidWord              cmdSsid,
    input  logic [hitMapPkg::ROWBITS-1:0]   cmdRow,          // row reads only
    output logic                            cmdAck,
    output logic                            busy,            // clear pass after reset
    // read results
    output logic                            resultValid,
    output logic                            resultIsRow,
    output logic [hitMapPkg::SSIDBITS-1:0]  resultSsid,
    output logic                            resultBit,
    output logic [hitMapPkg::ROWBITS-1:0]   resultRowIndex,
    output hitMapPkg::rowWord               resultRow
);

    logic [hitMapPkg::ROWBITS-1:0] rdRow;           // RAM read address
    hitMapPkg::rowWord             ramReadData;     // fans out to both pipelines
    logic                          setPending;      // sets in flight, stalls reads
    logic                          setValid;
    logic [hitMapPkg::ROWBITS-1:0] setRow;
    logic [hitMapPkg::COLBITS-1:0] setCol;
    logic                          readValid;
    logic                          readIsRow;
    logic [hitMapPkg::ROWBITS-1:0] readRow;
    logic [hitMapPkg::COLBITS-1:0] readCol;
    logic                          mergeWrEn;       // merge pipe write-back
    logic [hitMapPkg::ROWBITS-1:0] mergeWrRow;
    hitMapPkg::rowWord             mergeWrData;
    logic                          wrEn;            // RAM write port
    logic [hitMapPkg::ROWBITS-1:0] wrRow;
    hitMapPkg::rowWord             wrData;

    commandPort cmdPort (
        .clk(clk), .reset(reset),
        .cmdReq(cmdReq), .cmdOp(cmdOp), .cmdSsid(cmdSsid), .cmdRow(cmdRow), .cmdAck(cmdAck),
        .busy(busy), .setPending(setPending), .rdRow(rdRow),
        .setValid(setValid), .setRow(setRow), .setCol(setCol),
        .readValid(readValid), .readIsRow(readIsRow), .readRow(readRow), .readCol(readCol)
    );

    hitMergePipe mergePipe (
        .clk(clk), .reset(reset),
        .setValid(setValid), .setRow(setRow), .setCol(setCol), .rdData(ramReadData),
        .setPending(setPending),
        .mergeWrEn(mergeWrEn), .mergeWrRow(mergeWrRow), .mergeWrData(mergeWrData)
    );

    readTracker tracker (
        .clk(clk), .reset(reset),
        .readValid(readValid), .readIsRow(readIsRow), .readRow(readRow), .readCol(readCol),
        .rdData(ramReadData),
        .resultValid(resultValid), .resultIsRow(resultIsRow), .resultSsid(resultSsid),
        .resultBit(resultBit), .resultRowIndex(resultRowIndex), .resultRow(resultRow)
    );

    clearSequencer clearSeq (
        .clk(clk), .reset(reset),
        .mergeWrEn(mergeWrEn), .mergeWrRow(mergeWrRow), .mergeWrData(mergeWrData),
        .busy(busy), .wrEn(wrEn), .wrRow(wrRow), .wrData(wrData)
    );

    hitMapRam ram (
        .clk(clk), .wrEn(wrEn), .wrRow(wrRow), .wrData(wrData),
        .rdRow(rdRow), .rdData(ramReadData)
    );

endmodule

//--- sim/clockGen.sv
`timescale 1ns/10ps

module clockGen #(
    parameter time PERIOD = 40ns    // full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;                 // start low so the first edge is a rising one
        forever begin
            #(PERIOD / 2) clk = ~clk; // half period per phase
        end
    end

endmodule

//--- sim/hitMapTb_sva.sv
`timescale 1ns/10ps

module hitMapTb_sva (
    input logic clk,
    input logic reset,
    input logic cmdReq,
    input logic cmdAck,
    input logic busy,
    input logic readValid,      // internal accepted-read strobe of the top level
    input logic resultValid
);

    // ack only rises for a request that was up at that edge
    ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
        $rose(cmdAck) |-> $past(cmdReq))
        else $error("cmdAck rose without cmdReq");

    // nothing is accepted during the clear pass
    noAckWhileBusy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !cmdAck)
        else $error("cmdAck high while busy");

    // read result pulses READLATENCY cycles after ack rose
    readLatency: assert property (@(posedge clk) disable iff (reset)
        ($rose(cmdAck) && $past(readValid)) |-> ##(hitMapPkg::READLATENCY) resultValid)
        else $error("resultValid missing after read ack");

endmodule

bind hitMapTop hitMapTb_sva sva (
    .clk(clk), .reset(reset), .cmdReq(cmdReq), .cmdAck(cmdAck), .busy(busy),
    .readValid(readValid), .resultValid(resultValid)
);

//--- sim/hitMapTb.sv
`timescale 1ns/10ps

module hitMapTb;

    localparam int PERIOD = 40;             // ns
    localparam int DRIVEDELAY = 2;          // inputs change this long after the rising edge
    localparam int RESETCYCLES = 4;
    localparam int TESTCOMMANDS = 420;      // upper bound on commands over all tests
    localparam int WORSTCYCLES = 12;        // pending-set stall plus both handshake phases
    localparam int CLEARCYCLES = hitMapPkg::NUMROWS + hitMapPkg::CLEARSETTLE + RESETCYCLES + 2;
    localparam longint TIMEOUT = longint'(TESTCOMMANDS * WORSTCYCLES + 2 * CLEARCYCLES) * PERIOD;

    logic clk;
    logic reset;
    logic cmdReq;
    hitMapPkg::opCode cmdOp;
    hitMapPkg::ssidWord cmdSsid;
    logic [hitMapPkg::ROWBITS-1:0] cmdRow;
    logic cmdAck;
    logic busy;
    logic resultValid;
    logic resultIsRow;
    logic [hitMapPkg::SSIDBITS-1:0] resultSsid;
    logic resultBit;
    logic [hitMapPkg::ROWBITS-1:0] resultRowIndex;
    hitMapPkg::rowWord resultRow;

    hitMapPkg::rowWord model [hitMapPkg::NUMROWS]; // expected map contents
    int cycleCount = 0;                     // rising edges so far
    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;
    int expCycle [$];                       // outstanding reads, in issue order
    logic expIsRow [$];
    logic [hitMapPkg::SSIDBITS-1:0] expSsid [$];
    logic [hitMapPkg::ROWBITS-1:0] expRow [$];
    hitMapPkg::rowWord expValue [$];
    logic [hitMapPkg::SSIDBITS-1:0] setList [$]; // ssids set in test 2

    clockGen #(.PERIOD(40ns)) clockSource (.clk(clk));

    hitMapTop uut (
        .clk(clk), .reset(reset),
        .cmdReq(cmdReq), .cmdOp(cmdOp), .cmdSsid(cmdSsid), .cmdRow(cmdRow),
        .cmdAck(cmdAck), .busy(busy),
        .resultValid(resultValid), .resultIsRow(resultIsRow), .resultSsid(resultSsid),
        .resultBit(resultBit), .resultRowIndex(resultRowIndex), .resultRow(resultRow)
    );

    always @(posedge clk) cycleCount++;     // cycle stamp for latency checks

    // expected read data, row or one bit in position 0
    function automatic hitMapPkg::rowWord refResult(input logic isRow,
            input hitMapPkg::ssidWord s, input logic [hitMapPkg::ROWBITS-1:0] r);
        hitMapPkg::rowWord v;
        v = '0;
        if (isRow) v = model[r];
        else v[0] = model[s.rc.row][s.rc.col];
        return v;
    endfunction

    // one full four-phase transaction, entered a little after a rising edge
    task automatic runCommand(input hitMapPkg::opCode op,
            input logic [hitMapPkg::SSIDBITS-1:0] ssid, input logic [hitMapPkg::ROWBITS-1:0] row);
        hitMapPkg::ssidWord s;
        s.flat = ssid;
        cmdOp = op;
        cmdSsid = s;
        cmdRow = row;
        cmdReq = 1'b1;                      // phase 1
        do begin
            @(posedge clk);
            #DRIVEDELAY;
        end while (!cmdAck);                // phase 2, ack rose at the last edge
        if (op == hitMapPkg::OPSETHIT) begin
            model[s.rc.row][s.rc.col] = 1'b1; // the set ORs in one bit
        end else begin
            expCycle.push_back(cycleCount + hitMapPkg::READLATENCY);
            expIsRow.push_back(op == hitMapPkg::OPREADROW);
            expSsid.push_back(ssid);
            expRow.push_back(row);
            expValue.push_back(refResult(op == hitMapPkg::OPREADROW, s, row));
        end
        cmdReq = 1'b0;                      // phase 3
        do begin
            @(posedge clk);
            #DRIVEDELAY;
        end while (cmdAck);                 // phase 4
    endtask

    // reset, clear the model and time the clear pass
    task automatic applyReset();
        int busyCycles;
        busyCycles = 0;
        reset = 1'b1;
        repeat (RESETCYCLES) @(posedge clk);
        #DRIVEDELAY;
        reset = 1'b0;
        for (int r = 0; r < hitMapPkg::NUMROWS; r++) model[r] = '0;
        while (busy) begin
            busyCycles++;
            if (cmdAck) begin
                $display("cmdAck rose during the clear pass");
                errorCount++;
            end
            @(posedge clk);
            #DRIVEDELAY;
        end
        if (busyCycles != hitMapPkg::NUMROWS + hitMapPkg::CLEARSETTLE) begin
            $display("FAILED busy cycles got 0x%h expected 0x%h", busyCycles,
                     hitMapPkg::NUMROWS + hitMapPkg::CLEARSETTLE);
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int startErrors);
        while (expCycle.size() > 0) @(posedge clk); // every read has come back
        repeat (2) @(posedge clk);
        #DRIVEDELAY;
        testCount++;
        $display("test %0d %s: %0d errors", testCount, name, errorCount - startErrors);
    endtask

    task automatic readAllRows();
        for (int r = 0; r < hitMapPkg::NUMROWS; r++) begin
            runCommand(hitMapPkg::OPREADROW, '0, hitMapPkg::ROWBITS'(r));
        end
    endtask

    // compare each result pulse, sampled mid-cycle where outputs are stable
    always @(negedge clk) begin : compareResults
        int wantCycle;
        logic wantIsRow;
        logic [hitMapPkg::SSIDBITS-1:0] wantSsid;
        logic [hitMapPkg::ROWBITS-1:0] wantRow;
        hitMapPkg::rowWord wantValue;
        if (!reset && resultValid) begin
            checkCount++;
            if (expCycle.size() == 0) begin
                $display("read result arrived with no read outstanding");
                errorCount++;
            end else begin
                wantCycle = expCycle.pop_front();
                wantIsRow = expIsRow.pop_front();
                wantSsid = expSsid.pop_front();
                wantRow = expRow.pop_front();
                wantValue = expValue.pop_front();
                if (cycleCount != wantCycle) begin
                    $display("read result came at cycle %0d instead of cycle %0d",
                             cycleCount, wantCycle);
                    errorCount++;
                end
                if (resultIsRow != wantIsRow) begin
                    $display("FAILED resultIsRow got 0x%h expected 0x%h", resultIsRow, wantIsRow);
                    errorCount++;
                end else if (wantIsRow) begin
                    if (resultRowIndex != wantRow) begin
                        $display("FAILED resultRowIndex got 0x%h expected 0x%h",
                                 resultRowIndex, wantRow);
                        errorCount++;
                    end
                    if (resultRow != wantValue) begin
                        $display("FAILED resultRow row 0x%h got 0x%h expected 0x%h",
                                 wantRow, resultRow, wantValue);
                        errorCount++;
                    end
                end else begin
                    if (resultSsid != wantSsid) begin
                        $display("FAILED resultSsid got 0x%h expected 0x%h", resultSsid, wantSsid);
                        errorCount++;
                    end
                    if (resultBit != wantValue[0]) begin
                        $display("FAILED resultBit ssid 0x%h got 0x%h expected 0x%h",
                                 wantSsid, resultBit, wantValue[0]);
                        errorCount++;
                    end
                end
            end
        end
    end

    // bounded run length
    initial begin
        #(TIMEOUT);
        $display("watchdog expired, the DUT stopped answering commands");
        $display("test failed");
        $finish;
    end

    initial begin : stimulus
        int startErrors;
        logic [hitMapPkg::SSIDBITS-1:0] ssid;
        logic [hitMapPkg::ROWBITS-1:0] row;
        int pick;
        void'($urandom(32'hdb35_817b));    // seed once
        reset = 1'b1;
        cmdReq = 1'b0;
        cmdOp = hitMapPkg::OPSETHIT;
        cmdSsid = '0;
        cmdRow = '0;

        startErrors = errorCount;           // 1: clean map after reset
        applyReset();
        for (int i = 0; i < 32; i++) begin
            runCommand(hitMapPkg::OPREADBIT, hitMapPkg::SSIDBITS'($urandom), '0);
        end
        readAllRows();
        finishTest("reads after reset", startErrors);

        startErrors = errorCount;           // 2: random sets then bit reads
        for (int i = 0; i < 40; i++) begin
            ssid = hitMapPkg::SSIDBITS'($urandom);
            setList.push_back(ssid);
            runCommand(hitMapPkg::OPSETHIT, ssid, '0);
        end
        foreach (setList[i]) runCommand(hitMapPkg::OPREADBIT, setList[i], '0);
        for (int i = 0; i < 40; i++) begin
            do ssid = hitMapPkg::SSIDBITS'($urandom);
            while (model[ssid[hitMapPkg::SSIDBITS-1:hitMapPkg::COLBITS]]
                        [ssid[hitMapPkg::COLBITS-1:0]]); // untouched ssid only
            runCommand(hitMapPkg::OPREADBIT, ssid, '0);
        end
        finishTest("set and bit read", startErrors);

        startErrors = errorCount;           // 3: rows hold the OR of their sets
        readAllRows();
        finishTest("row read", startErrors);

        startErrors = errorCount;           // 4: back-to-back sets on one row
        row = hitMapPkg::ROWBITS'($urandom);
        for (int c = 0; c < hitMapPkg::NUMCOLS; c++) begin
            runCommand(hitMapPkg::OPSETHIT, {row, hitMapPkg::COLBITS'(c)}, '0);
        end
        runCommand(hitMapPkg::OPREADROW, '0, row);
        finishTest("same-row merging", startErrors);

        startErrors = errorCount;           // 5: reset mid-run wipes the map
        for (int i = 0; i < 20; i++) begin
            runCommand(hitMapPkg::OPSETHIT, hitMapPkg::SSIDBITS'($urandom), '0);
        end
        fork
            applyReset();
            begin
                repeat (RESETCYCLES + 2) @(posedge clk);
                #DRIVEDELAY;
                runCommand(hitMapPkg::OPREADROW, '0, row); // request held during the clear pass
            end
        join
        readAllRows();
        for (int i = 0; i < 16; i++) begin
            runCommand(hitMapPkg::OPREADBIT, hitMapPkg::SSIDBITS'($urandom), '0);
        end
        finishTest("reset mid-run", startErrors);

        startErrors = errorCount;           // 6: mixed traffic, latency and tags
        for (int i = 0; i < 60; i++) begin
            pick = $urandom_range(0, 2);
            runCommand(hitMapPkg::opCode'(pick), hitMapPkg::SSIDBITS'($urandom),
                       hitMapPkg::ROWBITS'($urandom));
        end
        finishTest("mixed latency and tags", startErrors);

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- hitMapTop.f
hdl/hitMapPkg.sv
hdl/hitMapRam.sv
hdl/commandPort.sv
hdl/hitMergePipe.sv
hdl/readTracker.sv
hdl/clearSequencer.sv
hdl/hitMapTop.sv
sim/clockGen.sv
sim/hitMapTb_sva.sv
sim/hitMapTb.sv

//--- Makefile
# Verilator build and run for the hit map testbench

VERILATOR ?= verilator
TOP       ?= hitMapTb
FILELIST  ?= hitMapTop.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASSMSG   ?= test passed

SOURCES := $(wildcard hdl/*.sv) $(wildcard sim/*.sv)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# pass or fail comes from the log, not the simulator exit code
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^$(PASSMSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
